/* vlog.f */
source/soc_pkg.sv
source/bus_decoder.sv
source/sram_slave.sv
source/wdt_slave.sv
source/soc_top.sv
sim/tb_clock_gen.sv
sim/soc_top_assertions.sv
sim/soc_top_tb.sv

/* Bender.yml */
package:
  name: soc_top

sources:
  - files:
      - source/soc_pkg.sv
      - source/bus_decoder.sv
      - source/sram_slave.sv
      - source/wdt_slave.sv
      - source/soc_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/soc_top_assertions.sv
      - sim/soc_top_tb.sv

/* sim/soc_top_tb.sv */
module soc_top_tb;

    localparam int sram_words = 256;

    typedef enum logic [1:0] {
        match_exact,
        match_shadow,
        match_at_most
    } match_t;

    typedef enum logic [1:0] {
        irq_none,
        irq_high_after,
        irq_low_during
    } irq_check_t;

    typedef struct packed {
        soc_pkg::bus_req_t req;
        logic [7:0]        idle_cycles;
        logic [7:0]        ready_delay;
        soc_pkg::data_t    exp_rdata;
        soc_pkg::resp_t    exp_resp;
        match_t            match;
        irq_check_t        irq_check;
        logic [7:0]        irq_cycles;
    } entry_t;

    logic              clk;
    logic              reset;
    soc_pkg::bus_req_t req;
    logic              req_valid;
    logic              req_ready;
    soc_pkg::bus_rsp_t rsp;
    logic              rsp_valid;
    logic              rsp_ready;
    logic              wto_interrupt;

    entry_t            entries[$];
    string             names[$];
    soc_pkg::data_t    shadow [sram_words];
    integer            seed;
    int                error_count = 0;
    int                cycle_count = 0;
    int                timeout_limit = 0;

    tb_clock_gen #(
        .period       (20),
        .reset_cycles (2)
    ) tb_clock_gen_inst (
        .clk   (clk),
        .reset (reset)
    );

    soc_top soc_top_inst (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .wto_interrupt (wto_interrupt)
    );

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
        end
    endtask

    function automatic soc_pkg::bus_req_t make_req(input soc_pkg::addr_t addr,
                                                   input logic write,
                                                   input soc_pkg::data_t wdata,
                                                   input soc_pkg::strb_t wstrb);
        soc_pkg::bus_req_t r;
        r.addr  = addr;
        r.write = write;
        r.wdata = wdata;
        r.wstrb = wstrb;
        return r;
    endfunction

    function automatic void add_entry(input string name, input soc_pkg::bus_req_t r,
                                      input int idle, input int delay,
                                      input soc_pkg::data_t exp_rdata,
                                      input soc_pkg::resp_t exp_resp, input match_t match,
                                      input irq_check_t irq_check = irq_none,
                                      input int irq_cycles = 0);
        entry_t e;
        e.req         = r;
        e.idle_cycles = 8'(idle);
        e.ready_delay = 8'(delay);
        e.exp_rdata   = exp_rdata;
        e.exp_resp    = exp_resp;
        e.match       = match;
        e.irq_check   = irq_check;
        e.irq_cycles  = 8'(irq_cycles);
        entries.push_back(e);
        names.push_back(name);
    endfunction

    // Byte lanes with strobe set take the new data
    function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_word,
                                                   input soc_pkg::data_t wdata,
                                                   input soc_pkg::strb_t wstrb);
        soc_pkg::data_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic soc_pkg::data_t rand_word();
        return soc_pkg::data_t'($random(seed));
    endfunction

    // ========================================
    // Stimulus table
    // ========================================
    task automatic build_table();
        add_entry("sram_wr_full_0", make_req(32'h0, 1'b1, rand_word(), 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_wr_full_1", make_req(32'h4, 1'b1, rand_word(), 4'hf), 1, 2,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_wr_full_top", make_req(32'h3fc, 1'b1, rand_word(), 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_wr_low_half", make_req(32'h0, 1'b1, rand_word(), 4'h3), 0, 1,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_wr_high_half", make_req(32'h4, 1'b1, rand_word(), 4'hc), 2, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_wr_odd_bytes", make_req(32'h3fc, 1'b1, rand_word(), 4'h5), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_rd_0", make_req(32'h0, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_shadow);
        add_entry("sram_rd_1_stall", make_req(32'h4, 1'b0, 32'h0, 4'h0), 0, 5,
                  32'h0, soc_pkg::resp_okay, match_shadow);
        add_entry("sram_rd_top", make_req(32'h3fc, 1'b0, 32'h0, 4'h0), 1, 0,
                  32'h0, soc_pkg::resp_okay, match_shadow);
        add_entry("dec_above_sram", make_req(32'h400, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'h0, soc_pkg::resp_decerr, match_exact);
        add_entry("dec_gap_write", make_req(32'h0800_0000, 1'b1, rand_word(), 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_decerr, match_exact);
        add_entry("dec_past_wdt", make_req(32'h1000_0010, 1'b0, 32'h0, 4'h0), 0, 3,
                  32'h0, soc_pkg::resp_decerr, match_exact);
        add_entry("dec_below_wdt", make_req(32'h0fff_fffc, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'h0, soc_pkg::resp_decerr, match_exact);
        add_entry("wdt_count_write", make_req(32'h1000_000c, 1'b1, 32'h5, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_slverr, match_exact);
        add_entry("wdt_bad_offset", make_req(32'h1000_0002, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'h0, soc_pkg::resp_slverr, match_exact);
        // Watchdog setup and readback
        add_entry("wdt_reload_100", make_req(32'h1000_0004, 1'b1, 32'd100, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_enable", make_req(32'h1000_0000, 1'b1, 32'h1, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_ctrl_read", make_req(32'h1000_0000, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'h1, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_reload_read", make_req(32'h1000_0004, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'd100, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_count_read", make_req(32'h1000_000c, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'd100, soc_pkg::resp_okay, match_at_most);
        // Timeout and kick with a long reload
        add_entry("wdt_reload_20", make_req(32'h1000_0004, 1'b1, 32'd20, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_kick_timeout", make_req(32'h1000_0008, 1'b1, 32'h0, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact, irq_high_after, 30);
        add_entry("wdt_reload_1000", make_req(32'h1000_0004, 1'b1, 32'd1000, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_kick_clear", make_req(32'h1000_0008, 1'b1, 32'h0, 4'hf), 0, 1,
                  32'h0, soc_pkg::resp_okay, match_exact, irq_low_during, 50);
        add_entry("wdt_disable", make_req(32'h1000_0000, 1'b1, 32'h0, 4'hf), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("wdt_ctrl_read_off", make_req(32'h1000_0000, 1'b0, 32'h0, 4'h0), 0, 0,
                  32'h0, soc_pkg::resp_okay, match_exact);
        add_entry("sram_rd_0_again", make_req(32'h0, 1'b0, 32'h0, 4'h0), 3, 2,
                  32'h0, soc_pkg::resp_okay, match_shadow);
    endtask

    // ========================================
    // One bus transaction
    // ========================================
    task automatic run_entry(input int i);
        entry_t            e;
        string             name;
        soc_pkg::bus_rsp_t held;
        soc_pkg::data_t    exp_rdata;
        int                latency;
        e    = entries[i];
        name = names[i];
        repeat (e.idle_cycles) @(posedge clk);
        @(posedge clk);
        req       <= e.req;
        req_valid <= 1'b1;
        rsp_ready <= 1'b0;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        // Acceptance edge
        @(posedge clk);
        req_valid <= 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end while (!rsp_valid && latency < 10);
        check_value(name, "latency", 32'd3, 32'(latency));
        held = rsp;
        for (int k = 0; k < e.ready_delay; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_value(name, "rsp_valid held", 32'h1, 32'(rsp_valid));
            check_value(name, "rsp held", {30'h0, held.resp}, {30'h0, rsp.resp});
            check_value(name, "rdata held", held.rdata, rsp.rdata);
            check_value(name, "req_ready stalled", 32'h0, 32'(req_ready));
        end
        @(posedge clk);
        rsp_ready <= 1'b1;
        @(negedge clk);
        case (e.match)
            match_shadow: exp_rdata = shadow[e.req.addr[9:2]];
            default:      exp_rdata = e.exp_rdata;
        endcase
        if (e.match == match_at_most) begin
            // Counter runs down from reload and has not reached zero yet
            check_value(name, "count below reload", 32'h1,
                        32'(rsp.rdata < exp_rdata && rsp.rdata != '0));
        end else begin
            check_value(name, "rdata", exp_rdata, rsp.rdata);
        end
        check_value(name, "resp", {30'h0, e.exp_resp}, {30'h0, rsp.resp});
        @(posedge clk);
        rsp_ready <= 1'b0;
        @(negedge clk);
        check_value(name, "rsp_valid after transfer", 32'h0, 32'(rsp_valid));
        check_value(name, "req_ready after transfer", 32'h1, 32'(req_ready));
        if (e.req.write && e.req.addr < soc_pkg::addr_t'(4 * sram_words)) begin
            shadow[e.req.addr[9:2]] = merge_bytes(shadow[e.req.addr[9:2]],
                                                  e.req.wdata, e.req.wstrb);
        end
        if (e.irq_check == irq_high_after) begin
            repeat (e.irq_cycles) @(posedge clk);
            @(negedge clk);
            check_value(name, "wto_interrupt", 32'h1, 32'(wto_interrupt));
        end else if (e.irq_check == irq_low_during) begin
            for (int k = 0; k < e.irq_cycles; k++) begin
                @(negedge clk);
                check_value(name, "wto_interrupt", 32'h0, 32'(wto_interrupt));
            end
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int irq_total;
        seed      = 32'h2e65;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        irq_total = 0;
        build_table();
        foreach (entries[i]) begin
            irq_total += entries[i].irq_cycles;
        end
        timeout_limit = entries.size() * 40 + irq_total + 10;

        wait (reset === 1'b0);
        @(negedge clk);
        check_value("after_reset", "req_ready", 32'h1, 32'(req_ready));
        check_value("after_reset", "rsp_valid", 32'h0, 32'(rsp_valid));
        check_value("after_reset", "wto_interrupt", 32'h0, 32'(wto_interrupt));

        foreach (entries[i]) begin
            run_entry(i);
        end
        repeat (2) @(posedge clk);

        $display("Check errors: %0d, assertion failures: %0d", error_count,
                 soc_top_inst.soc_top_assertions_inst.assert_failures);
        if (error_count == 0 && soc_top_inst.soc_top_assertions_inst.assert_failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Run limit in clock cycles
    initial begin
        @(posedge clk);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("Check errors: %0d, assertion failures: %0d", error_count,
                 soc_top_inst.soc_top_assertions_inst.assert_failures);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* sim/soc_top_assertions.sv */
module soc_top_assertions (
    input logic              clk,
    input logic              reset,
    input soc_pkg::bus_req_t req,
    input logic              req_valid,
    input logic              req_ready,
    input soc_pkg::bus_rsp_t rsp,
    input logic              rsp_valid,
    input logic              rsp_ready,
    input logic              sram_sel,
    input logic              wdt_sel
);

    int assert_failures = 0;

    // ========================================
    // Handshake rules
    // ========================================
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !req_ready) |=> $stable(req))
        else begin
            $error("req changed while waiting for req_ready");
            assert_failures++;
        end

    rsp_held: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else begin
            $error("rsp_valid or rsp changed before rsp_ready");
            assert_failures++;
        end

    // Never strobe both slaves
    sel_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({sram_sel, wdt_sel}))
        else begin
            $error("sram_sel and wdt_sel high together");
            assert_failures++;
        end

endmodule

bind soc_top soc_top_assertions soc_top_assertions_inst (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .sram_sel  (sram_sel),
    .wdt_sel   (wdt_sel)
);

/* sim/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* source/soc_top.sv */
module soc_top #(
    parameter int sram_words      = 256,
    parameter int wdt_count_width = 16
) (
    input  logic              clk,
    input  logic              reset,

    input  soc_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,

    output soc_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,

    output logic              wto_interrupt
);

    soc_pkg::bus_req_t slave_req;
    soc_pkg::bus_rsp_t sram_rsp;
    soc_pkg::bus_rsp_t wdt_rsp;
    logic              sram_sel;
    logic              wdt_sel;

    // ========================================
    // Decoder and slaves
    // ========================================
    bus_decoder #(
        .sram_words (sram_words)
    ) bus_decoder_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .slave_req (slave_req),
        .sram_sel  (sram_sel),
        .wdt_sel   (wdt_sel),
        .sram_rsp  (sram_rsp),
        .wdt_rsp   (wdt_rsp)
    );

    sram_slave #(
        .sram_words (sram_words)
    ) sram_slave_inst (
        .clk       (clk),
        .reset     (reset),
        .slave_req (slave_req),
        .sel       (sram_sel),
        .rsp       (sram_rsp)
    );

    wdt_slave #(
        .wdt_count_width (wdt_count_width)
    ) wdt_slave_inst (
        .clk           (clk),
        .reset         (reset),
        .slave_req     (slave_req),
        .sel           (wdt_sel),
        .rsp           (wdt_rsp),
        .wto_interrupt (wto_interrupt)
    );

endmodule

/* source/wdt_slave.sv */
module wdt_slave #(
    parameter int wdt_count_width = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  soc_pkg::bus_req_t slave_req,
    input  logic              sel,
    output soc_pkg::bus_rsp_t rsp,
    output logic              wto_interrupt
);

    typedef logic [wdt_count_width-1:0] count_t;

    logic                      enable;
    count_t                    reload;
    count_t                    count;
    soc_pkg::reg_off_t         offset;
    soc_pkg::bus_rsp_t         rsp_next;

    assign offset = slave_req.addr[3:0];

    // ========================================
    // Counter and register writes
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            enable        <= 1'b0;
            reload        <= '0;
            count         <= '0;
            wto_interrupt <= 1'b0;
        end else begin
            if (enable) begin
                if (count != '0) begin
                    count <= count - 1'b1;
                end else begin
                    wto_interrupt <= 1'b1;
                end
            end

            // Bus writes take priority over the countdown
            if (sel && slave_req.write) begin
                case (offset)
                    soc_pkg::wdt_ctrl_off: begin
                        enable        <= slave_req.wdata[0];
                        wto_interrupt <= 1'b0;
                        if (slave_req.wdata[0]) begin
                            count <= reload;
                        end
                    end
                    soc_pkg::wdt_reload_off: begin
                        reload <= count_t'(slave_req.wdata);
                    end
                    soc_pkg::wdt_kick_off: begin
                        count         <= reload;
                        wto_interrupt <= 1'b0;
                    end
                endcase
            end
        end
    end

    // ========================================
    // Read data and response code
    // ========================================
    always_comb begin
        rsp_next.rdata = '0;
        rsp_next.resp  = soc_pkg::resp_okay;
        case (offset)
            soc_pkg::wdt_ctrl_off: begin
                if (!slave_req.write) begin
                    rsp_next.rdata = soc_pkg::data_t'(enable);
                end
            end
            soc_pkg::wdt_reload_off: begin
                if (!slave_req.write) begin
                    rsp_next.rdata = soc_pkg::data_t'(reload);
                end
            end
            soc_pkg::wdt_kick_off: begin
                rsp_next.rdata = '0;
            end
            soc_pkg::wdt_count_off: begin
                // count is read only
                if (slave_req.write) begin
                    rsp_next.resp = soc_pkg::resp_slverr;
                end else begin
                    rsp_next.rdata = soc_pkg::data_t'(count);
                end
            end
            default: begin
                rsp_next.resp = soc_pkg::resp_slverr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp <= '{rdata: '0, resp: soc_pkg::resp_okay};
        end else if (sel) begin
            rsp <= rsp_next;
        end
    end

endmodule

/* source/sram_slave.sv */
module sram_slave #(
    parameter int sram_words = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  soc_pkg::bus_req_t slave_req,
    input  logic              sel,
    output soc_pkg::bus_rsp_t rsp
);

    localparam int index_width = $clog2(sram_words);

    soc_pkg::data_t         mem [sram_words];
    logic [index_width-1:0] index;

    // Word index, byte offset dropped
    assign index = slave_req.addr[index_width+1:2];

    // ========================================
    // Byte-masked write port
    // ========================================
    always_ff @(posedge clk) begin
        if (sel && slave_req.write) begin
            for (int i = 0; i < 4; i++) begin
                if (slave_req.wstrb[i]) begin
                    mem[index][8*i +: 8] <= slave_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read data, one cycle after sel
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp <= '{rdata: '0, resp: soc_pkg::resp_okay};
        end else if (sel) begin
            rsp.resp <= soc_pkg::resp_okay;
            if (slave_req.write) begin
                rsp.rdata <= '0;
            end else begin
                rsp.rdata <= mem[index];
            end
        end
    end

endmodule

/* source/bus_decoder.sv */
module bus_decoder #(
    parameter int sram_words = 256
) (
    input  logic              clk,
    input  logic              reset,

    input  soc_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,

    output soc_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready,

    output soc_pkg::bus_req_t slave_req,
    output logic              sram_sel,
    output logic              wdt_sel,
    input  soc_pkg::bus_rsp_t sram_rsp,
    input  soc_pkg::bus_rsp_t wdt_rsp
);

    localparam soc_pkg::addr_t sram_limit =
        soc_pkg::sram_base + soc_pkg::addr_t'(4 * sram_words);
    localparam soc_pkg::addr_t wdt_limit = soc_pkg::wdt_base + soc_pkg::wdt_span;

    typedef enum logic [1:0] {
        idle,
        access,
        capture,
        respond
    } state_t;

    typedef enum logic [1:0] {
        target_none,
        target_sram,
        target_wdt
    } target_t;

    state_t            state;
    target_t           target;
    target_t           addr_target;
    logic              strobe_phase;
    soc_pkg::bus_req_t req_q;
    soc_pkg::bus_rsp_t rsp_q;

    // ========================================
    // Address decode
    // ========================================
    always_comb begin
        if (req_q.addr < sram_limit) begin
            addr_target = target_sram;
        end else if (req_q.addr >= soc_pkg::wdt_base && req_q.addr < wdt_limit) begin
            addr_target = target_wdt;
        end else begin
            addr_target = target_none;
        end
    end

    // ========================================
    // Transaction FSM
    // ========================================
    // Access takes two cycles: decode first, then the slave strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            target       <= target_none;
            strobe_phase <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req_valid) begin
                        state <= access;
                    end
                end
                access: begin
                    if (!strobe_phase) begin
                        target       <= addr_target;
                        strobe_phase <= 1'b1;
                    end else begin
                        strobe_phase <= 1'b0;
                        state        <= capture;
                    end
                end
                capture: begin
                    state <= respond;
                end
                respond: begin
                    if (rsp_ready) begin
                        state  <= idle;
                        target <= target_none;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Request and response holding registers
    always_ff @(posedge clk) begin
        if (state == idle && req_valid) begin
            req_q <= req;
        end
        if (state == capture) begin
            case (target)
                target_sram: rsp_q <= sram_rsp;
                target_wdt:  rsp_q <= wdt_rsp;
                default:     rsp_q <= '{rdata: '0, resp: soc_pkg::resp_decerr};
            endcase
        end
    end

    assign req_ready = (state == idle);
    assign rsp_valid = (state == respond);
    assign rsp       = rsp_q;
    assign slave_req = req_q;

    // One-cycle strobes, none for an unmapped address
    assign sram_sel = (state == access) && strobe_phase && (target == target_sram);
    assign wdt_sel  = (state == access) && strobe_phase && (target == target_wdt);

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

    // ========================================
    // Bus types
    // ========================================
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } resp_t;

    // Single-beat request, read or write
    typedef struct packed {
        addr_t addr;
        logic  write;
        data_t wdata;
        strb_t wstrb;
    } bus_req_t;

    typedef struct packed {
        data_t rdata;
        resp_t resp;
    } bus_rsp_t;

    // ========================================
    // Address map
    // ========================================
    localparam addr_t sram_base = 32'h0000_0000;
    localparam addr_t wdt_base  = 32'h1000_0000;
    localparam addr_t wdt_span  = 32'd16;

    // Watchdog register offsets within its window
    typedef logic [3:0] reg_off_t;

    localparam reg_off_t wdt_ctrl_off   = 4'h0;
    localparam reg_off_t wdt_reload_off = 4'h4;
    localparam reg_off_t wdt_kick_off   = 4'h8;
    localparam reg_off_t wdt_count_off  = 4'hc;

endpackage
